/* run_sim.sh */
#!/usr/bin/env bash
# build the pokey testbench with verilator, run it, look for the pass line
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module pokey_tb -f verilog.f -o pokey_sim; then
    echo "verilator build failed"
    exit 1
fi

sim_output="$(./obj_dir/pokey_sim 2>&1)"
sim_status=$?
printf '%s\n' "$sim_output"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qF "all tests passed" <<< "$sim_output"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

/* src/pokey_channel.sv */
`default_nettype none

module pokey_channel (
    input  wire logic            nextChn,
    input  wire logic            reset,
    input  pokey_pkg::chan_ctrl_t ctrl,
    input  wire logic            reload,
    input  wire logic            base_tick,
    input  wire logic            poly4_bit,
    input  wire logic            poly5_bit,
    input  wire logic            poly17_bit,
    output pokey_pkg::chan_out_t out
);

    pokey_pkg::freq_div_t cnt;        // down counter in base ticks
    logic                 div_pulse;  // counter wrapped this cycle
    logic [2:0]           distort;
    logic                 vol_only;
    pokey_pkg::volume_t   volume;
    logic                 gate;       // poly5 gating passes this pulse
    logic                 next_bit;   // value loaded in noise modes
    logic                 audio_q;

    // audc fields
    assign distort  = ctrl.audc[7:5];
    assign vol_only = ctrl.audc[4];
    assign volume   = ctrl.audc[3:0];

    // tick that finds zero is the divider output, a reload takes priority
    assign div_pulse = base_tick && (cnt == '0) && !reload;

    // divider, AUDF+1 ticks between pulses
    always_ff @(posedge nextChn) begin
        if (reset) begin
            cnt <= '0;
        end else if (reload) begin
            cnt <= ctrl.audf;                // fresh AUDF write
        end else if (base_tick) begin
            if (cnt == '0) begin
                cnt <= ctrl.audf;            // wrap
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // bit 7 clear means the poly5 stream masks pulses
    assign gate = distort[2] || poly5_bit;

    // bit 6 picks the noise source
    assign next_bit = distort[1] ? poly4_bit : poly17_bit;

    always_ff @(posedge nextChn) begin
        if (reset) begin
            audio_q <= 1'b0;
        end else if (div_pulse && gate) begin
            if (distort[0]) begin
                audio_q <= !audio_q;         // pure tone
            end else begin
                audio_q <= next_bit;         // noise sample
            end
        end
    end

    // volume-only holds the output high, dac level straight from volume
    always_comb begin
        out.audio = audio_q || vol_only;
        out.vol   = out.audio ? volume : '0;
    end

endmodule

`default_nettype wire

/* src/pokey_output_select.sv */
`default_nettype none

module pokey_output_select (
    input  wire logic             nextChn,
    input  wire logic             reset,
    input  pokey_pkg::chan_out_t  chans [pokey_pkg::NUM_CHANNELS],
    input  pokey_pkg::chan_sel_t  mon_sel,
    output logic                  audio_out,
    output pokey_pkg::volume_t    vol_out,
    output pokey_pkg::mix_t       mix_out
);

    pokey_pkg::mix_t      sum;  // all four gated volumes
    pokey_pkg::chan_out_t mon;  // channel picked by MONSEL

    // widen each volume before adding so the carry is kept
    always_comb begin
        sum = '0;
        for (int i = 0; i < pokey_pkg::NUM_CHANNELS; i++) begin
            sum = sum + pokey_pkg::mix_t'(chans[i].vol);
        end
    end

    assign mon = chans[mon_sel];   // 4:1 mux

    // everything out of here is one cycle behind the channels
    always_ff @(posedge nextChn) begin
        if (reset) begin
            audio_out <= 1'b0;
            vol_out   <= '0;
            mix_out   <= '0;
        end else begin
            audio_out <= mon.audio;
            vol_out   <= mon.vol;
            mix_out   <= sum;      // stands in for the analog mixer
        end
    end

endmodule

`default_nettype wire

/* src/pokey_pkg.sv */
`default_nettype none

package pokey_pkg;

    // meaningful widths
    typedef logic [3:0] reg_addr_t;   // host register address
    typedef logic [7:0] reg_data_t;   // host register data
    typedef logic [7:0] freq_div_t;   // AUDFn divider
    typedef logic [3:0] volume_t;     // per channel volume
    typedef logic [5:0] mix_t;        // four volumes summed, max 60
    typedef logic [1:0] chan_sel_t;   // channel index
    typedef logic [6:0] presc_t;      // base tick prescaler, holds up to DIV_15K-1

    localparam int NUM_CHANNELS = 4;

    // interleaved map: AUDFn at even, AUDCn at odd addresses 0..7
    localparam reg_addr_t ADDR_AUDF   = 4'd0;
    localparam reg_addr_t ADDR_AUDC   = 4'd1;
    localparam reg_addr_t ADDR_AUDCTL = 4'd8;
    localparam reg_addr_t ADDR_MONSEL = 4'd9;   // 10..15 unmapped

    // nextChn cycles per base tick
    localparam int DIV_64K = 28;
    localparam int DIV_15K = 114;

    // lfsr start values, any non-zero pattern works
    localparam logic [3:0]  POLY4_SEED  = 4'b1111;
    localparam logic [4:0]  POLY5_SEED  = 5'b10101;
    localparam logic [16:0] POLY17_SEED = 17'h1ACE1;

    // host write payload
    typedef struct packed {
        reg_addr_t addr;
        reg_data_t data;
    } reg_write_t;

    // one channel's control, audc = {distortion[2:0], vol_only, volume[3:0]}
    typedef struct packed {
        freq_div_t audf;
        reg_data_t audc;
    } chan_ctrl_t;

    // one channel's result
    typedef struct packed {
        logic    audio;
        volume_t vol;
    } chan_out_t;

endpackage

`default_nettype wire

/* src/pokey_reg_decode.sv */
`default_nettype none

module pokey_reg_decode (
    input  wire logic                                 nextChn,
    input  wire logic                                 reset,
    input  wire logic                                 wr_req,
    input  pokey_pkg::reg_write_t                     wr,
    output logic                                      wr_ack,
    output pokey_pkg::chan_ctrl_t                     chan_ctrl [pokey_pkg::NUM_CHANNELS],
    output logic [pokey_pkg::NUM_CHANNELS-1:0]        reload,
    output logic                                      base_15k,
    output pokey_pkg::chan_sel_t                      mon_sel
);

    logic                 take;      // first cycle of a new request
    logic                 is_chan;   // AUDF/AUDC half of the map
    logic                 is_audf;
    logic                 is_audc;
    pokey_pkg::chan_sel_t idx;       // channel addressed

    // ack low means idle, so req high here is a fresh write
    assign take    = wr_req && !wr_ack;

    // addr[3] clear selects the channel block, addr[2:1] the channel
    assign is_chan = (wr.addr < pokey_pkg::ADDR_AUDCTL);
    assign idx     = wr.addr[2:1];
    assign is_audf = (wr.addr[0] == pokey_pkg::ADDR_AUDF[0]);  // even address
    assign is_audc = (wr.addr[0] == pokey_pkg::ADDR_AUDC[0]);  // odd address

    // handshake flag
    always_ff @(posedge nextChn) begin
        if (reset) begin
            wr_ack <= 1'b0;
        end else if (take) begin
            wr_ack <= 1'b1;                  // high the cycle after the store
        end else if (!wr_req) begin
            wr_ack <= 1'b0;                  // host released, back to idle
        end
    end

    // register file, written on the same edge that raises ack
    always_ff @(posedge nextChn) begin
        if (reset) begin
            reload   <= '0;
            base_15k <= 1'b0;
            mon_sel  <= '0;
            for (int i = 0; i < pokey_pkg::NUM_CHANNELS; i++) begin
                chan_ctrl[i] <= '0;
            end
        end else begin
            reload <= '0;                    // one cycle pulse only
            if (take) begin
                if (is_chan) begin
                    if (is_audf) begin
                        chan_ctrl[idx].audf <= wr.data;
                        reload[idx]         <= 1'b1;   // restart that divider
                    end
                    if (is_audc) begin
                        chan_ctrl[idx].audc <= wr.data;
                    end
                end else if (wr.addr == pokey_pkg::ADDR_AUDCTL) begin
                    base_15k <= wr.data[0];  // only bit 0 is kept
                end else if (wr.addr == pokey_pkg::ADDR_MONSEL) begin
                    mon_sel  <= wr.data[1:0];
                end
                // anything else is acked and dropped
            end
        end
    end

endmodule

`default_nettype wire

/* src/pokey_timebase.sv */
`default_nettype none

module pokey_timebase (
    input  wire logic nextChn,
    input  wire logic reset,
    input  wire logic base_15k,
    output logic      base_tick,
    output logic      poly4_bit,
    output logic      poly5_bit,
    output logic      poly17_bit
);

    pokey_pkg::presc_t presc;       // cycles since last tick
    pokey_pkg::presc_t term;        // terminal count for current mode
    logic              base_15k_q;  // mode seen last cycle
    logic              mode_chg;

    logic [3:0]  poly4;
    logic [4:0]  poly5;
    logic [16:0] poly17;

    // 28 or 114 cycles per tick
    assign term = base_15k ? pokey_pkg::presc_t'(pokey_pkg::DIV_15K - 1)
                           : pokey_pkg::presc_t'(pokey_pkg::DIV_64K - 1);

    assign mode_chg = (base_15k != base_15k_q);

    // no tick in the cycle where the mode flips
    assign base_tick = (presc == term) && !mode_chg;

    always_ff @(posedge nextChn) begin
        if (reset) begin
            base_15k_q <= 1'b0;
        end else begin
            base_15k_q <= base_15k;
        end
    end

    // prescaler
    always_ff @(posedge nextChn) begin
        if (reset) begin
            presc <= '0;
        end else if (mode_chg) begin
            presc <= '0;                     // restart on AUDCTL bit 0 change
        end else if (presc == term) begin
            presc <= '0;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    // fibonacci lfsrs, shift left, feedback into bit 0
    // x^4 + x^3 + 1
    always_ff @(posedge nextChn) begin
        if (reset) begin
            poly4 <= pokey_pkg::POLY4_SEED;
        end else begin
            poly4 <= {poly4[2:0], poly4[3] ^ poly4[2]};
        end
    end

    // x^5 + x^3 + 1
    always_ff @(posedge nextChn) begin
        if (reset) begin
            poly5 <= pokey_pkg::POLY5_SEED;
        end else begin
            poly5 <= {poly5[3:0], poly5[4] ^ poly5[2]};
        end
    end

    // x^17 + x^14 + 1, period 131071
    always_ff @(posedge nextChn) begin
        if (reset) begin
            poly17 <= pokey_pkg::POLY17_SEED;
        end else begin
            poly17 <= {poly17[15:0], poly17[16] ^ poly17[13]};
        end
    end

    // msb of each as the noise bit
    assign poly4_bit  = poly4[3];
    assign poly5_bit  = poly5[4];
    assign poly17_bit = poly17[16];

endmodule

`default_nettype wire

/* src/pokey_top.sv */
`default_nettype none

module pokey_top (
    input  wire logic             nextChn,
    input  wire logic             reset,
    input  wire logic             wr_req,
    input  pokey_pkg::reg_write_t wr,
    output logic                  wr_ack,
    output logic                  audio_out,
    output pokey_pkg::volume_t    vol_out,
    output pokey_pkg::mix_t       mix_out
);

    pokey_pkg::chan_ctrl_t                  chan_ctrl [pokey_pkg::NUM_CHANNELS];
    logic [pokey_pkg::NUM_CHANNELS-1:0]     reload;     // per channel AUDF write strobe
    logic                                   base_15k;
    pokey_pkg::chan_sel_t                   mon_sel;
    logic                                   base_tick;
    logic                                   poly4_bit;
    logic                                   poly5_bit;
    logic                                   poly17_bit;
    pokey_pkg::chan_out_t                   chans [pokey_pkg::NUM_CHANNELS];

    // decode
    pokey_reg_decode u_decode (
        .nextChn   (nextChn),
        .reset     (reset),
        .wr_req    (wr_req),
        .wr        (wr),
        .wr_ack    (wr_ack),
        .chan_ctrl (chan_ctrl),
        .reload    (reload),
        .base_15k  (base_15k),
        .mon_sel   (mon_sel)
    );

    // shared tick and noise sources
    pokey_timebase u_timebase (
        .nextChn    (nextChn),
        .reset      (reset),
        .base_15k   (base_15k),
        .base_tick  (base_tick),
        .poly4_bit  (poly4_bit),
        .poly5_bit  (poly5_bit),
        .poly17_bit (poly17_bit)
    );

    // four identical channels
    for (genvar g = 0; g < pokey_pkg::NUM_CHANNELS; g++) begin : g_chan
        pokey_channel u_chan (
            .nextChn    (nextChn),
            .reset      (reset),
            .ctrl       (chan_ctrl[g]),
            .reload     (reload[g]),
            .base_tick  (base_tick),
            .poly4_bit  (poly4_bit),
            .poly5_bit  (poly5_bit),
            .poly17_bit (poly17_bit),
            .out        (chans[g])
        );
    end

    // result
    pokey_output_select u_result (
        .nextChn   (nextChn),
        .reset     (reset),
        .chans     (chans),
        .mon_sel   (mon_sel),
        .audio_out (audio_out),
        .vol_out   (vol_out),
        .mix_out   (mix_out)
    );

endmodule

`default_nettype wire

/* verif/pokey_assertions.sv */
`default_nettype none

module pokey_assertions (
    input wire logic nextChn,
    input wire logic reset,
    input wire logic wr_req,
    input wire logic wr_ack
);

    timeunit 1ns;
    timeprecision 1ps;

    // ack is registered, so look at req on the edge that moved it
    a_ack_rise: assert property (@(posedge nextChn) disable iff (reset)
        $rose(wr_ack) |-> $past(wr_req))
        else $error("wr_ack rose with no request pending");

    a_ack_fall: assert property (@(posedge nextChn) disable iff (reset)
        $fell(wr_ack) |-> !$past(wr_req))
        else $error("wr_ack fell while the request was still high");

    // idle right out of reset
    a_reset_idle: assert property (@(posedge nextChn) reset |=> !wr_ack)
        else $error("wr_ack high in the cycle after reset");

endmodule

bind pokey_reg_decode pokey_assertions u_assertions (
    .nextChn (nextChn),
    .reset   (reset),
    .wr_req  (wr_req),
    .wr_ack  (wr_ack)
);

`default_nettype wire

/* verif/pokey_tb.sv */
`default_nettype none

module pokey_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // what to check after each row's write
    localparam logic [2:0] K_NONE  = 3'd0;  // write only
    localparam logic [2:0] K_TONE  = 3'd1;  // exact toggle interval
    localparam logic [2:0] K_NOISE = 3'd2;  // interval a multiple of expected
    localparam logic [2:0] K_CONST = 3'd3;  // vol_out sample
    localparam logic [2:0] K_MIX   = 3'd4;  // mix_out sample

    localparam int NUM_ROWS     = 26;
    localparam int RESET_CYCLES = 4;
    localparam int ROW_MARGIN   = 2000;     // write plus slack for sparse noise edges

    typedef struct packed {
        pokey_pkg::reg_addr_t addr;
        pokey_pkg::reg_data_t data;
        logic [2:0]           kind;
        int                   expected;
    } row_t;

    // audc = {distortion, vol_only, volume}, tone interval = (AUDF+1)*DIV
    localparam row_t ROWS [NUM_ROWS] = '{
        '{4'd1, 8'hA9, K_NONE, 0},                                // AUDC1 tone, vol 9
        '{4'd0, 8'h05, K_TONE, (5 + 1) * pokey_pkg::DIV_64K},     // AUDF1 = 5
        '{4'd1, 8'h13, K_NONE, 0},                                // vol-only 3
        '{4'd3, 8'h15, K_NONE, 0},                                // vol-only 5
        '{4'd5, 8'h17, K_NONE, 0},                                // vol-only 7
        '{4'd7, 8'h1F, K_MIX, 30},                                // vol-only 15
        '{4'd9, 8'h00, K_CONST, 3},                               // MONSEL walk
        '{4'd9, 8'h01, K_CONST, 5},
        '{4'd9, 8'h01, K_MIX, 30},
        '{4'd9, 8'h02, K_CONST, 7},
        '{4'd9, 8'h02, K_MIX, 30},
        '{4'd9, 8'h03, K_CONST, 15},
        '{4'd9, 8'h03, K_MIX, 30},
        '{4'd9, 8'h00, K_CONST, 3},
        '{4'd1, 8'hA9, K_NONE, 0},                                // back to tone
        '{4'd8, 8'h01, K_NONE, 0},                                // AUDCTL 15 kHz
        '{4'd0, 8'h05, K_TONE, (5 + 1) * pokey_pkg::DIV_15K},
        '{4'd8, 8'h00, K_TONE, (5 + 1) * pokey_pkg::DIV_64K},     // 64 kHz again
        '{4'd0, 8'h02, K_NONE, 0},                                // AUDF1 = 2
        '{4'd1, 8'h0A, K_NOISE, (2 + 1) * pokey_pkg::DIV_64K},    // dist 000
        '{4'd1, 8'h4A, K_NOISE, (2 + 1) * pokey_pkg::DIV_64K},    // dist 010
        '{4'd1, 8'h8A, K_NOISE, (2 + 1) * pokey_pkg::DIV_64K},    // dist 100
        '{4'd1, 8'hA9, K_NONE, 0},
        '{4'd12, 8'hFF, K_TONE, (2 + 1) * pokey_pkg::DIV_64K},    // unmapped
        '{4'd1, 8'h13, K_MIX, 30},
        '{4'd12, 8'h55, K_MIX, 30}                                // unmapped
    };

    logic                  nextChn;
    logic                  reset;
    logic                  wr_req;
    pokey_pkg::reg_write_t wr;
    logic                  wr_ack;
    logic                  audio_out;
    pokey_pkg::volume_t    vol_out;
    pokey_pkg::mix_t       mix_out;

    // register model for the volume monitor
    pokey_pkg::reg_data_t  audc_model [pokey_pkg::NUM_CHANNELS];
    pokey_pkg::chan_sel_t  mon_model;
    logic                  writing;         // monitor off while a write settles
    int                    cycle_count = 0;
    int                    cycle_limit;

    pokey_top DUT (
        .nextChn   (nextChn),
        .reset     (reset),
        .wr_req    (wr_req),
        .wr        (wr),
        .wr_ack    (wr_ack),
        .audio_out (audio_out),
        .vol_out   (vol_out),
        .mix_out   (mix_out)
    );

    initial begin
        nextChn = 1'b0;
        forever #50 nextChn = ~nextChn;    // 100 ns period
    end

    task automatic check_value(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("MISMATCH at time %0t: %s, got %0d, expected %0d",
                     $time, what, actual, expected);
            $display("tests failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // two measured intervals per measuring row plus a margin for every row
    function automatic int compute_limit();
        int total;
        total = RESET_CYCLES;
        for (int i = 0; i < NUM_ROWS; i++) begin
            total = total + ROW_MARGIN;
            if (ROWS[i].kind == K_TONE || ROWS[i].kind == K_NOISE) begin
                total = total + 2 * ROWS[i].expected;
            end
        end
        return total;
    endfunction

    always @(posedge nextChn) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_limit);
            $display("tests failed");
            $fatal(1, "cycle limit reached");
        end
    end

    // gated volume, monitored channel's level when high, zero when low
    always @(negedge nextChn) begin
        if (!reset && !writing) begin
            if (audio_out) begin
                check_value(int'(vol_out), int'(audc_model[mon_model][3:0]),
                            "vol_out while audio_out high");
            end else begin
                check_value(int'(vol_out), 0, "vol_out while audio_out low");
            end
        end
    end

    // full four-phase write, ack expected one cycle after each req edge
    task automatic write_reg(input pokey_pkg::reg_addr_t addr,
                             input pokey_pkg::reg_data_t data);
        int latency;
        writing = 1'b1;
        @(negedge nextChn);
        wr.addr = addr;
        wr.data = data;
        wr_req  = 1'b1;
        latency = 0;
        while (!wr_ack) begin
            @(negedge nextChn);
            latency++;
        end
        check_value(latency, 1, "wr_ack rise latency");
        wr_req  = 1'b0;
        latency = 0;
        while (wr_ack) begin
            @(negedge nextChn);
            latency++;
        end
        check_value(latency, 1, "wr_ack fall latency");
        if (addr < pokey_pkg::ADDR_AUDCTL && addr[0]) begin
            audc_model[addr[2:1]] = data;  // AUDCn at odd addresses
        end else if (addr == pokey_pkg::ADDR_MONSEL) begin
            mon_model = data[1:0];
        end
        writing = 1'b0;
    endtask

    // cycles between the next two edges of audio_out
    task automatic measure_interval(output int cycles);
        logic level;
        level = audio_out;
        while (audio_out == level) begin
            @(negedge nextChn);
        end
        level  = audio_out;
        cycles = 0;
        while (audio_out == level) begin
            @(negedge nextChn);
            cycles++;
        end
    endtask

    initial begin
        row_t row;
        int   cycles;
        reset   = 1'b1;
        wr_req  = 1'b0;
        wr      = '0;
        writing = 1'b0;
        mon_model = '0;
        for (int c = 0; c < pokey_pkg::NUM_CHANNELS; c++) begin
            audc_model[c] = '0;
        end
        cycle_limit = compute_limit();
        repeat (RESET_CYCLES) @(posedge nextChn);
        @(negedge nextChn);
        reset = 1'b0;

        check_value(int'(wr_ack), 0, "wr_ack after reset");
        check_value(int'(audio_out), 0, "audio_out after reset");
        check_value(int'(vol_out), 0, "vol_out after reset");
        check_value(int'(mix_out), 0, "mix_out after reset");

        for (int i = 0; i < NUM_ROWS; i++) begin
            row = ROWS[i];
            write_reg(row.addr, row.data);
            case (row.kind)
                K_TONE: begin
                    measure_interval(cycles);
                    check_value(cycles, row.expected, $sformatf("row %0d tone interval", i));
                end
                K_NOISE: begin
                    measure_interval(cycles);
                    check_value(cycles % row.expected, 0,
                                $sformatf("row %0d noise edge spacing %0d", i, cycles));
                end
                K_CONST: check_value(int'(vol_out), row.expected,
                                     $sformatf("row %0d vol_out", i));
                K_MIX:   check_value(int'(mix_out), row.expected,
                                     $sformatf("row %0d mix_out", i));
                default: ;  // write only
            endcase
        end

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
src/pokey_pkg.sv
src/pokey_reg_decode.sv
src/pokey_timebase.sv
src/pokey_channel.sv
src/pokey_output_select.sv
src/pokey_top.sv
verif/pokey_assertions.sv
verif/pokey_tb.sv
